/* Makefile */
TOP := tb_mips_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* axil_mem.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module axil_mem (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  mips_mem_pkg::axil_addr_t  awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  mips_mem_pkg::axil_wdata_t wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output mips_mem_pkg::axil_resp_e  bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  mips_mem_pkg::axil_addr_t  araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`DATA_W-1:0]        rdata,
    output mips_mem_pkg::axil_resp_e  rresp
);
    import mips_mem_pkg::*;

    localparam int             IDX_W    = $clog2(`MEM_WORDS);
    localparam int             CNT_W    = $clog2(`MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`MEM_LATENCY - 1);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    axil_addr_t         aw_q;
    axil_wdata_t        w_q;
    logic               aw_full;
    logic               w_full;
    logic               wr_go;
    logic [IDX_W-1:0]   ar_idx;
    logic [CNT_W-1:0]   wcnt;
    logic [CNT_W-1:0]   rcnt;

    // Ready is given only once both halves of the write are held and no response is pending.
    assign wr_go   = aw_full && w_full && (wcnt == '0) && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bresp   = OKAY;
    assign rresp   = OKAY;

    always_ff @(posedge clk) begin
        if (awvalid && !aw_full) aw_q <= awaddr;
        if (wvalid && !w_full) w_q <= wdata;
        if (arvalid && arready) ar_idx <= araddr.addr[IDX_W+1:2];
        if (rcnt == CNT_W'(1)) rdata <= mem[ar_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_go) begin
            for (int b = 0; b < `DATA_W / 8; b++) begin
                if (w_q.strb[b]) mem[aw_q.addr[IDX_W+1:2]][8*b +: 8] <= w_q.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            wcnt    <= '0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rcnt    <= '0;
            rvalid  <= 1'b0;
        end else begin
            aw_full <= wr_go ? 1'b0 : (aw_full || awvalid);
            w_full  <= wr_go ? 1'b0 : (w_full || wvalid);
            if (wr_go) begin
                wcnt <= CNT_LOAD;
            end else if (wcnt != '0) begin
                wcnt <= wcnt - 1'b1;
            end
            bvalid <= (wcnt == CNT_W'(1)) || (bvalid && !bready);

            // Address ready comes one cycle after the request.
            arready <= arvalid && !arready && (rcnt == '0) && !rvalid;
            if (arvalid && arready) begin
                rcnt <= CNT_LOAD;
            end else if (rcnt != '0) begin
                rcnt <= rcnt - 1'b1;
            end
            rvalid <= (rcnt == CNT_W'(1)) || (rvalid && !rready);
        end
    end

endmodule

/* compile.f */
+incdir+.
mips_isa_pkg.sv
mips_mem_pkg.sv
instr_decoder.sv
dcache_array.sv
dcache_ctrl.sv
axil_mem.sv
mips_ctrl_top.sv
tb_mips_ctrl.sv

/* dcache_array.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module dcache_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [$clog2(`MEM_WORDS)+1:0] addr,
    output logic                          hit,
    output logic                          dirty,
    output logic [`DATA_W-1:0]            rdata,
    output logic [$clog2(`MEM_WORDS)+1:0] victim_addr,
    output logic [`DATA_W-1:0]            victim_data,
    input  logic                          wr_en,
    input  logic [`DATA_W-1:0]            wr_data,
    input  logic                          set_dirty
);
    localparam int ADDR_W = $clog2(`MEM_WORDS) + 2;
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0]       tag_mem  [`CACHE_LINES];
    logic [`DATA_W-1:0]     data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;
    logic [IDX_W-1:0]       idx;
    logic [TAG_W-1:0]       tag;

    // Bits 1:0 select a byte and play no part, since every access is a whole word.
    assign idx = addr[IDX_W+1:2];
    assign tag = addr[ADDR_W-1:IDX_W+2];

    assign hit         = valid_q[idx] && (tag_mem[idx] == tag);
    assign dirty       = valid_q[idx] && dirty_q[idx];
    assign rdata       = data_mem[idx];
    assign victim_data = data_mem[idx];
    assign victim_addr = {tag_mem[idx], idx, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= set_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= wr_data;
        end
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module dcache_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_valid,
    input  mips_isa_pkg::ctrl_t              ctrl,
    input  logic [`DATA_W-1:0]               addr,
    input  logic [`DATA_W-1:0]               store_data,
    input  logic                             hit,
    input  logic                             dirty,
    input  logic [$clog2(`MEM_WORDS)+1:0]    victim_addr,
    input  logic [`DATA_W-1:0]               victim_data,
    output logic                             wr_en,
    output logic [`DATA_W-1:0]               wr_data,
    output logic                             set_dirty,
    output logic                             awvalid,
    input  logic                             awready,
    output mips_mem_pkg::axil_addr_t         awaddr,
    output logic                             wvalid,
    input  logic                             wready,
    output mips_mem_pkg::axil_wdata_t        wdata,
    input  logic                             bvalid,
    output logic                             bready,
    input  mips_mem_pkg::axil_resp_e         bresp,
    output logic                             arvalid,
    input  logic                             arready,
    output mips_mem_pkg::axil_addr_t         araddr,
    input  logic                             rvalid,
    output logic                             rready,
    input  logic [`DATA_W-1:0]               rdata,
    input  mips_mem_pkg::axil_resp_e         rresp,
    output logic [`DATA_W-1:0]               fill_data,
    output logic                             advance
);
    import mips_mem_pkg::*;

    localparam int ADDR_W = $clog2(`MEM_WORDS) + 2;

    miss_state_e state;
    miss_state_e state_nxt;
    logic        mem_op;
    logic        aw_done;
    logic        w_done;
    logic        aw_hs;
    logic        w_hs;

    assign mem_op = ctrl.mem_read || ctrl.mem_write;
    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;

    // Address and data may be accepted in different cycles, so each keeps its own flag.
    assign awvalid = (state == WB_REQ) && !aw_done;
    assign wvalid  = (state == WB_REQ) && !w_done;
    assign awaddr  = '{addr: {{(32 - ADDR_W){1'b0}}, victim_addr}, prot: 3'b000};
    assign wdata   = '{data: victim_data, strb: '1};
    assign arvalid = (state == FILL_REQ);
    assign araddr  = '{addr: {addr[`DATA_W-1:2], 2'b00}, prot: 3'b000};
    assign bready  = 1'b1;
    assign rready  = 1'b1;

    always_comb begin
        state_nxt = state;
        wr_en     = 1'b0;
        wr_data   = store_data;
        set_dirty = 1'b1;
        advance   = 1'b0;
        case (state)
            IDLE: begin
                if (instr_valid && (!mem_op || hit)) begin
                    advance = 1'b1;
                    wr_en   = ctrl.mem_write;
                end else if (instr_valid) begin
                    state_nxt = dirty ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ: begin
                if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                    state_nxt = WB_RESP;
                end
            end
            // The memory never errs, so bresp and rresp do not change the sequence.
            WB_RESP: if (bvalid) state_nxt = FILL_REQ;
            FILL_REQ: if (arvalid && arready) state_nxt = FILL_RESP;
            FILL_RESP: begin
                if (rvalid) begin
                    wr_en     = 1'b1;
                    wr_data   = ctrl.mem_write ? store_data : rdata;
                    set_dirty = ctrl.mem_write;
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Back in IDLE the refilled line hits, which gives advance one cycle after the response.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state_nxt != WB_REQ) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_done || aw_hs;
                w_done  <= w_done || w_hs;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            fill_data <= rdata;
        end
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module instr_decoder (
    input  mips_isa_pkg::instr_t instr,
    output mips_isa_pkg::ctrl_t  ctrl
);
    import mips_isa_pkg::*;

    logic is_alu_imm;
    logic is_branch;

    assign is_alu_imm = instr.opcode inside {OP_ADDI, OP_ADDIU, OP_ANDI, OP_XORI,
                                             OP_ORI, OP_SLTI, OP_LUI};
    assign is_branch  = instr.opcode inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;

        case (instr.opcode)
            OP_RTYPE: begin
                case (instr.func)
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SLLV: ctrl.alu_op = ALU_SLLV;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRLV: ctrl.alu_op = ALU_SRLV;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_MULT: ctrl.alu_op = ALU_MULT;
                    FN_DIV:  ctrl.alu_op = ALU_DIV;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.alu_op        = ALU_JR;
                        ctrl.jump_register = 1'b1;
                    end
                    FN_ADD, FN_ADDU, FN_SYSCALL: ctrl.alu_op = ALU_ADD;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_ANDI: ctrl.alu_op = ALU_AND;
            OP_XORI: ctrl.alu_op = ALU_XOR;
            OP_ORI:  ctrl.alu_op = ALU_OR;
            OP_SLTI: ctrl.alu_op = ALU_SLT;
            OP_LUI:  ctrl.alu_op = ALU_LUI;
            OP_BEQ:  ctrl.alu_op = ALU_BEQ;
            OP_BNE:  ctrl.alu_op = ALU_BNE;
            OP_BLEZ: ctrl.alu_op = ALU_BLEZ;
            OP_BGTZ: ctrl.alu_op = ALU_BGTZ;
            OP_BGEZ: ctrl.alu_op = ALU_BGEZ;
            // ADDI, ADDIU, loads, stores and jumps all use the adder.
            default: ctrl.alu_op = ALU_ADD;
        endcase

        ctrl.dest_sel    = (instr.opcode == OP_RTYPE) ? DEST_RD :
                           (instr.opcode == OP_JAL)   ? DEST_RA : DEST_RT;
        ctrl.reg_src     = (instr.opcode == OP_LW)  ? SRC_MEM :
                           (instr.opcode == OP_JAL) ? SRC_PC  : SRC_ALU;
        ctrl.jump        = instr.opcode inside {OP_J, OP_JAL};
        ctrl.branch      = is_branch;
        ctrl.mem_read    = (instr.opcode == OP_LW);
        ctrl.mem_write   = (instr.opcode == OP_SW);
        ctrl.alu_src     = is_alu_imm || is_branch || instr.opcode inside {OP_LW, OP_SW};
        ctrl.is_unsigned = instr.opcode inside {OP_ADDIU, OP_ANDI, OP_XORI, OP_ORI, OP_LUI};
        // The register file qualifies this with advance, so a load miss writes only once.
        ctrl.reg_write   = is_alu_imm || instr.opcode inside {OP_RTYPE, OP_LW, OP_JAL};
    end

endmodule

/* mips_ctrl_top.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_ctrl_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  mips_isa_pkg::instr_t instr,
    output mips_isa_pkg::ctrl_t  ctrl,
    output logic [`DATA_W-1:0]   rdata,
    output logic                 advance
);
    import mips_mem_pkg::*;

    localparam int ADDR_W = $clog2(`MEM_WORDS) + 2;

    logic               hit;
    logic               dirty;
    logic [`DATA_W-1:0] arr_rdata;
    logic [ADDR_W-1:0]  victim_addr;
    logic [`DATA_W-1:0] victim_data;
    logic               wr_en;
    logic [`DATA_W-1:0] wr_data;
    logic               set_dirty;
    logic [`DATA_W-1:0] fill_data;
    logic               awvalid;
    logic               awready;
    axil_addr_t         awaddr;
    logic               wvalid;
    logic               wready;
    axil_wdata_t        wdata;
    logic               bvalid;
    logic               bready;
    axil_resp_e         bresp;
    logic               arvalid;
    logic               arready;
    axil_addr_t         araddr;
    logic               rvalid;
    logic               rready;
    logic [`DATA_W-1:0] axi_rdata;
    axil_resp_e         rresp;

    instr_decoder u_instr_decoder (.instr(instr), .ctrl(ctrl));

    dcache_array u_dcache_array (
        .*,
        .addr (instr.addr[ADDR_W-1:0]),
        .rdata(arr_rdata)
    );

    dcache_ctrl u_dcache_ctrl (
        .*,
        .addr      (instr.addr),
        .store_data(instr.wdata),
        .rdata     (axi_rdata)
    );

    axil_mem u_axil_mem (.*, .rdata(axi_rdata));

    // After a refill the line hits again, so the refill word only shows while a miss is open.
    assign rdata = hit ? arr_rdata : fill_data;

endmodule

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    `include "mips_params.svh"

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000, OP_BGEZ  = 6'b000001, OP_J    = 6'b000010,
        OP_JAL   = 6'b000011, OP_BEQ   = 6'b000100, OP_BNE  = 6'b000101,
        OP_BLEZ  = 6'b000110, OP_BGTZ  = 6'b000111, OP_ADDI = 6'b001000,
        OP_ADDIU = 6'b001001, OP_SLTI  = 6'b001010, OP_ANDI = 6'b001100,
        OP_ORI   = 6'b001101, OP_XORI  = 6'b001110, OP_LUI  = 6'b001111,
        OP_LW    = 6'b100011, OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000, FN_SRL     = 6'b000010, FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV    = 6'b000110, FN_JR   = 6'b001000,
        FN_SYSCALL = 6'b001100, FN_MULT = 6'b011000, FN_DIV  = 6'b011010,
        FN_ADD  = 6'b100000, FN_ADDU    = 6'b100001, FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011, FN_AND     = 6'b100100, FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110, FN_NOR     = 6'b100111, FN_SLT  = 6'b101010
    } func_e;

    // Branch compares are carried out by the ALU, so they get their own codes.
    typedef enum logic [4:0] {
        ALU_XOR  = 5'd0,  ALU_SLL  = 5'd1,  ALU_SRL  = 5'd2,  ALU_SRA  = 5'd3,
        ALU_ADD  = 5'd4,  ALU_SUB  = 5'd5,  ALU_MULT = 5'd6,  ALU_DIV  = 5'd7,
        ALU_OR   = 5'd8,  ALU_NOR  = 5'd9,  ALU_AND  = 5'd10, ALU_SLT  = 5'd11,
        ALU_JR   = 5'd12, ALU_BEQ  = 5'd13, ALU_BNE  = 5'd14, ALU_BLEZ = 5'd15,
        ALU_BGTZ = 5'd16, ALU_BGEZ = 5'd17, ALU_LUI  = 5'd18, ALU_SLLV = 5'd25,
        ALU_SRLV = 5'd26
    } alu_op_e;

    typedef enum logic [1:0] {DEST_RT = 2'd0, DEST_RD = 2'd1, DEST_RA = 2'd2} dest_sel_e;

    typedef enum logic [1:0] {SRC_ALU = 2'd0, SRC_MEM = 2'd1, SRC_PC = 2'd2} reg_src_e;

    typedef struct packed {
        opcode_e             opcode;
        func_e               func;
        logic [`DATA_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
    } instr_t;

    typedef struct packed {
        dest_sel_e dest_sel;
        logic      jump;
        logic      branch;
        logic      jump_register;
        logic      mem_read;
        logic      mem_write;
        reg_src_e  reg_src;
        alu_op_e   alu_op;
        logic      alu_src;
        logic      reg_write;
        logic      is_unsigned;
    } ctrl_t;

endpackage

/* mips_mem_pkg.sv */
package mips_mem_pkg;

    `include "mips_params.svh"

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_addr_t;

    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
    } axil_wdata_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // Write-back states come first since a dirty miss must empty the line before refill.
    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_RESP,
        FILL_REQ,
        FILL_RESP
    } miss_state_e;

endpackage

/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Width of a data word and of the load and store path.
`define DATA_W 32

// Direct-mapped cache with one word per line.
`define CACHE_LINES 16

// Backing memory size in words.
`define MEM_WORDS 256

// Cycles between an accepted request and the memory response. Must be at least two.
`define MEM_LATENCY 4

`endif

/* tb_mips_ctrl.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_ctrl;
    import mips_isa_pkg::*;

    localparam int          HALF       = 4;
    localparam int          IDX_W      = $clog2(`MEM_WORDS);
    localparam int          N_RANDOM   = 200;
    localparam int          TEST_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'h0894_e45e;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    instr_t             instr;
    ctrl_t              ctrl;
    logic [`DATA_W-1:0] rdata;
    logic               advance;

    string              name_q  [$];
    instr_t             instr_q [$];
    ctrl_t              ctrl_q  [$];
    logic [`DATA_W-1:0] word_q  [$];
    logic [`DATA_W-1:0] ref_mem [`MEM_WORDS];
    logic [31:0]        lfsr_state;

    mips_ctrl_top u_mips_ctrl_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .ctrl       (ctrl),
        .rdata      (rdata),
        .advance    (advance)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF) clk = ~clk;
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Each bit taken costs one LFSR step.
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Flags are {jump, branch, jump_register, mem_read, mem_write, alu_src, reg_write, unsigned}.
    function automatic ctrl_t ctrl_word(dest_sel_e dest, reg_src_e src, alu_op_e op,
                                        logic [7:0] flags);
        ctrl_t c;
        c.dest_sel = dest;
        c.reg_src  = src;
        c.alu_op   = op;
        {c.jump, c.branch, c.jump_register, c.mem_read, c.mem_write,
         c.alu_src, c.reg_write, c.is_unsigned} = flags;
        return c;
    endfunction

    function automatic ctrl_t r_ctrl(alu_op_e op);
        return ctrl_word(DEST_RD, SRC_ALU, op, 8'b000_00_010);
    endfunction

    function automatic ctrl_t i_ctrl(alu_op_e op, logic uns);
        return ctrl_word(DEST_RT, SRC_ALU, op, {7'b000_00_11, uns});
    endfunction

    function automatic ctrl_t b_ctrl(alu_op_e op);
        return ctrl_word(DEST_RT, SRC_ALU, op, 8'b010_00_100);
    endfunction

    function automatic ctrl_t load_ctrl();
        return ctrl_word(DEST_RT, SRC_MEM, ALU_ADD, 8'b000_10_110);
    endfunction

    function automatic ctrl_t store_ctrl();
        return ctrl_word(DEST_RT, SRC_ALU, ALU_ADD, 8'b000_01_100);
    endfunction

    function automatic void add_decode(string name, opcode_e op, func_e fn, ctrl_t exp);
        instr_t ins;
        ins.opcode = op;
        ins.func   = fn;
        ins.addr   = '0;
        ins.wdata  = '0;
        name_q.push_back(name);
        instr_q.push_back(ins);
        ctrl_q.push_back(exp);
        word_q.push_back('0);
    endfunction

    // For a store the value is the data written, for a load the data expected back.
    function automatic void add_access(string name, logic is_store,
                                       logic [`DATA_W-1:0] addr, logic [`DATA_W-1:0] value);
        instr_t ins;
        ins.opcode = is_store ? OP_SW : OP_LW;
        ins.func   = FN_SLL;
        ins.addr   = addr;
        ins.wdata  = is_store ? value : '0;
        name_q.push_back(name);
        instr_q.push_back(ins);
        ctrl_q.push_back(is_store ? store_ctrl() : load_ctrl());
        word_q.push_back(is_store ? '0 : value);
    endfunction

    function automatic void build_table();
        add_decode("add", OP_RTYPE, FN_ADD, r_ctrl(ALU_ADD));
        add_decode("subu", OP_RTYPE, FN_SUBU, r_ctrl(ALU_SUB));
        add_decode("sll", OP_RTYPE, FN_SLL, r_ctrl(ALU_SLL));
        add_decode("srlv", OP_RTYPE, FN_SRLV, r_ctrl(ALU_SRLV));
        add_decode("nor", OP_RTYPE, FN_NOR, r_ctrl(ALU_NOR));
        add_decode("slt", OP_RTYPE, FN_SLT, r_ctrl(ALU_SLT));
        add_decode("mult", OP_RTYPE, FN_MULT, r_ctrl(ALU_MULT));
        add_decode("div", OP_RTYPE, FN_DIV, r_ctrl(ALU_DIV));
        add_decode("syscall", OP_RTYPE, FN_SYSCALL, r_ctrl(ALU_ADD));
        add_decode("jr", OP_RTYPE, FN_JR, ctrl_word(DEST_RD, SRC_ALU, ALU_JR, 8'b001_00_010));
        add_decode("addi", OP_ADDI, FN_SLL, i_ctrl(ALU_ADD, 1'b0));
        add_decode("addiu", OP_ADDIU, FN_SLL, i_ctrl(ALU_ADD, 1'b1));
        add_decode("andi", OP_ANDI, FN_SLL, i_ctrl(ALU_AND, 1'b1));
        add_decode("xori", OP_XORI, FN_SLL, i_ctrl(ALU_XOR, 1'b1));
        add_decode("slti", OP_SLTI, FN_SLL, i_ctrl(ALU_SLT, 1'b0));
        add_decode("lui", OP_LUI, FN_SLL, i_ctrl(ALU_LUI, 1'b1));
        add_decode("beq", OP_BEQ, FN_SLL, b_ctrl(ALU_BEQ));
        add_decode("bne", OP_BNE, FN_SLL, b_ctrl(ALU_BNE));
        add_decode("bgez", OP_BGEZ, FN_SLL, b_ctrl(ALU_BGEZ));
        add_decode("j", OP_J, FN_SLL, ctrl_word(DEST_RT, SRC_ALU, ALU_ADD, 8'b100_00_000));
        add_decode("jal", OP_JAL, FN_SLL, ctrl_word(DEST_RA, SRC_PC, ALU_ADD, 8'b100_00_010));
        add_decode("unknown", opcode_e'(6'b111111), FN_SLL,
                   ctrl_word(DEST_RT, SRC_ALU, ALU_ADD, 8'b000_00_000));
        add_access("lw_cold", 1'b0, 32'h040, 32'h0000_0000);
        add_access("sw_a", 1'b1, 32'h040, 32'hdead_beef);
        add_access("lw_a", 1'b0, 32'h040, 32'hdead_beef);
        // Lines 0x084 and 0x2c4 share index 1, so they keep evicting each other.
        add_access("sw_x", 1'b1, 32'h084, 32'h1111_0001);
        add_access("sw_y", 1'b1, 32'h2c4, 32'h2222_0002);
        add_access("lw_x", 1'b0, 32'h084, 32'h1111_0001);
        add_access("lw_y", 1'b0, 32'h2c4, 32'h2222_0002);
        add_access("sw_x2", 1'b1, 32'h084, 32'h3333_0003);
        add_access("lw_y2", 1'b0, 32'h2c4, 32'h2222_0002);
        add_access("lw_x2", 1'b0, 32'h084, 32'h3333_0003);
    endfunction

    task automatic check_ctrl(string name, ctrl_t exp, ctrl_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected ctrl %h, actual ctrl %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(string name, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected rdata %h, actual rdata %h", name, exp, act);
            abort_run();
        end
    endtask

    // Outputs are sampled one ns before the rising edge, once the inputs have settled.
    task automatic apply(string name, instr_t ins, ctrl_t exp_ctrl, logic [`DATA_W-1:0] exp_word);
        int                 waited;
        ctrl_t              got_ctrl;
        logic [`DATA_W-1:0] got_word;
        waited = 0;
        @(negedge clk);
        instr       = ins;
        instr_valid = 1'b1;
        #(HALF - 1);
        while (advance !== 1'b1) begin
            @(negedge clk);
            #(HALF - 1);
            waited++;
        end
        got_ctrl = ctrl;
        got_word = rdata;
        @(posedge clk);
        check_ctrl(name, exp_ctrl, got_ctrl);
        if (exp_ctrl.mem_read) begin
            check_word(name, exp_word, got_word);
        end
        if (!(exp_ctrl.mem_read || exp_ctrl.mem_write) && waited != 0) begin
            $display("Advance for %s came %0d cycles after instr_valid, not at once",
                     name, waited);
            abort_run();
        end
        if (exp_ctrl.mem_write) begin
            ref_mem[ins.addr[IDX_W+1:2]] = ins.wdata;
        end
    endtask

    initial begin
        #1;
        repeat (TEST_LIMIT * (name_q.size() + N_RANDOM + 1)) @(posedge clk);
        $display("The watchdog expired before all tests had finished.");
        abort_run();
    end

    initial begin
        instr_t           ins;
        logic             is_store;
        logic [IDX_W-1:0] word_idx;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = SEED;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        build_table();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #(HALF - 1);
        if (advance !== 1'b0) begin
            $display("Advance is high after reset with no instruction presented.");
            abort_run();
        end

        for (int n = 0; n < name_q.size(); n++) begin
            apply(name_q[n], instr_q[n], ctrl_q[n], word_q[n]);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            is_store   = (take_bits(1) != 32'd0);
            word_idx   = IDX_W'(take_bits(IDX_W));
            ins.opcode = is_store ? OP_SW : OP_LW;
            ins.func   = FN_SLL;
            ins.addr   = {{(`DATA_W - IDX_W - 2){1'b0}}, word_idx, 2'b00};
            ins.wdata  = take_bits(32);
            apply($sformatf("random_%0d", i), ins, is_store ? store_ctrl() : load_ctrl(),
                  ref_mem[word_idx]);
        end

        @(negedge clk);
        instr_valid = 1'b0;
        $display("=== PASS ===");
        $finish;
    end

endmodule
